// File: bench/ins_fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module ins_fetch_tb;

    localparam int    CLK_HALF    = 50;
    localparam int    DRIVE_DLY   = 10;     // inputs change this long after the rising edge
    localparam int    TAIL_CYCLES = 20;
    localparam string DATA_FILE   = "bench/ins_fetch_testdata.txt";

    logic                  clk;
    logic                  rst;
    logic                  irq;
    fetch_pkg::mem_addr_t  irq_addr;
    logic                  ret_valid;
    logic                  ins_ready;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    fetch_pkg::ins_word_t  mem_rsp_data;
    logic                  ins_valid;
    fetch_pkg::ins_addr_t  ins_addr;
    fetch_pkg::ins_word_t  ins_data;
    logic                  mem_req_valid;
    fetch_pkg::mem_addr_t  mem_req_addr;

    logic [15:0]           lfsr;
    int                    words_asked;
    int                    words_given;     // responses the memory has handed over
    logic                  rsp_pending;
    int                    rsp_wait;
    fetch_pkg::mem_addr_t  rsp_byte_addr;
    int                    xfer_left;       // transfers still wanted by the scenario
    logic                  ready_hold;
    logic                  irq_req;
    fetch_pkg::mem_addr_t  irq_byte;
    logic                  ret_req;
    logic                  xfer_seen;
    fetch_pkg::ins_addr_t  xfer_addr;
    fetch_pkg::ins_word_t  xfer_word;
    int                    wd_cycles;

    ins_fetch_top DUT
    (
        .clk           (clk),
        .rst           (rst),
        .irq           (irq),
        .irq_addr      (irq_addr),
        .ret_valid     (ret_valid),
        .ins_ready     (ins_ready),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .ins_valid     (ins_valid),
        .ins_addr      (ins_addr),
        .ins_data      (ins_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // fibonacci taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // word index in the low half and its inverse in the high half
    function automatic fetch_pkg::ins_word_t mem_word(input fetch_pkg::mem_addr_t byte_addr);
        logic [31:0] idx;
        idx = 32'(byte_addr >> 3);
        return {~idx, idx};
    endfunction

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input fetch_pkg::ins_addr_t got,
                              input fetch_pkg::ins_addr_t exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_word(input string name, input fetch_pkg::ins_word_t got,
                              input fetch_pkg::ins_word_t exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_mem_addr(input string name, input fetch_pkg::mem_addr_t got,
                                  input fetch_pkg::mem_addr_t exp);
        if (got !== exp)
        begin
            $display("error %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    // samples mid cycle and plays memory and drives inputs after the next edge
    task automatic run_cycle();
        logic                  req_fire;
        logic                  rsp_fire;
        logic [1:0]            dly_bits;
        fetch_pkg::mem_addr_t  req_addr;
        @(negedge clk);
        req_fire  = mem_req_valid && mem_req_ready;
        rsp_fire  = mem_rsp_valid;
        req_addr  = mem_req_addr;
        xfer_seen = ins_valid && ins_ready;
        xfer_addr = ins_addr;
        xfer_word = ins_data;
        if (ins_valid && int'(ins_addr) >= `TOTAL_ISA_DEPTH)
        begin
            $display("an instruction was offered past the end of the program image");
            stop_on_error();
        end
        if (ins_valid && int'(ins_addr) >= `ISA_DEPTH * (words_given / `ISA_DEPTH))
        begin
            $display("instruction %h was offered before its segment arrived", ins_addr);
            stop_on_error();
        end
        if (xfer_seen && xfer_left == 0)
        begin
            $display("an instruction was taken when none was expected");
            stop_on_error();
        end
        if (xfer_seen)
        begin
            xfer_left--;
        end
        if (req_fire && (rsp_pending || rsp_fire || words_asked >= `TOTAL_ISA_DEPTH))
        begin
            $display("a memory request came while one was outstanding or after the fill");
            stop_on_error();
        end
        if (req_fire)
        begin
            check_mem_addr("mem_req_addr", req_addr, fetch_pkg::mem_addr_t'(words_asked) << 3);
            words_asked++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        if (rsp_fire)
        begin
            mem_rsp_valid = 1'b0;
            words_given++;
        end
        if (rsp_pending)
        begin
            rsp_wait--;
            if (rsp_wait == 0)
            begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = mem_word(rsp_byte_addr);
                rsp_pending   = 1'b0;
            end
        end
        if (req_fire)
        begin
            dly_bits[1]   = rand_bit();
            dly_bits[0]   = rand_bit();
            rsp_pending   = 1'b1;
            rsp_byte_addr = req_addr;
            rsp_wait      = 1 + (int'(dly_bits) % 3);
        end
        mem_req_ready = rand_bit();
        if (ready_hold)
        begin
            ins_ready = 1'b1;
        end
        else if (xfer_left > 0)
        begin
            ins_ready = rand_bit();
        end
        else
        begin
            ins_ready = 1'b0;
        end
        irq       = irq_req;
        irq_addr  = irq_req ? irq_byte : '0;
        ret_valid = ret_req;
    endtask

    initial
    begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", wd_cycles);
        stop_on_error();
    end

    initial
    begin
        int                    fd;
        int                    code;
        int                    n_lines;
        int                    count;
        logic [63:0]           cmd;
        logic [1023:0]         line;
        fetch_pkg::ins_addr_t  exp_addr;
        fetch_pkg::mem_addr_t  byte_addr;
        rst           = 1'b0;
        irq           = 1'b0;
        irq_addr      = '0;
        ret_valid     = 1'b0;
        ins_ready     = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        lfsr          = 16'd11864;
        words_asked   = 0;
        words_given   = 0;
        rsp_pending   = 1'b0;
        rsp_wait      = 0;
        rsp_byte_addr = '0;
        xfer_left     = 0;
        ready_hold    = 1'b0;
        irq_req       = 1'b0;
        irq_byte      = '0;
        ret_req       = 1'b0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("the scenario file could not be opened");
            stop_on_error();
        end
        n_lines = 0;
        while (!$feof(fd))
        begin
            code = $fgets(line, fd);
            if (code > 0)
            begin
                n_lines++;
            end
        end
        $fclose(fd);
        wd_cycles = 400 * n_lines + 2000;
        fd = $fopen(DATA_FILE, "r");
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        code = $fscanf(fd, "%s", cmd);
        while (code == 1)
        begin
            if (cmd == "#")
            begin
                code = $fgets(line, fd);
            end
            else if (cmd == "accept")
            begin
                code      = $fscanf(fd, "%d", count);
                xfer_left = count;
                while (count > 0)
                begin
                    run_cycle();
                    if (xfer_seen)
                    begin
                        code = $fscanf(fd, "%h", exp_addr);
                        check_addr("ins_addr", xfer_addr, exp_addr);
                        check_word("ins_data", xfer_word,
                                   mem_word(fetch_pkg::mem_addr_t'(exp_addr) << 3));
                        count--;
                    end
                end
            end
            else if (cmd == "irq")
            begin
                code     = $fscanf(fd, "%h", byte_addr);
                irq_req  = 1'b1;
                irq_byte = byte_addr;
                run_cycle();
                irq_req = 1'b0;
                repeat (2) run_cycle();         // jump state passes
            end
            else if (cmd == "ret")
            begin
                ret_req = 1'b1;
                repeat (2) run_cycle();
                ret_req = 1'b0;
                repeat (3) run_cycle();         // falling edge and then the pop
            end
            else
            begin
                $display("the scenario file holds an unknown command");
                stop_on_error();
            end
            code = $fscanf(fd, "%s", cmd);
        end
        $fclose(fd);
        ready_hold = 1'b1;                      // after the last word nothing more may come
        repeat (TAIL_CYCLES) run_cycle();
        $display("test passed");
        $finish;
    end

endmodule

// File: bench/ins_fetch_testdata.txt
# accept <n>: take n instructions, their expected word addresses follow in hex
# irq <byte address in hex>: interrupt jump, ret: return to the saved address
accept 16
00 01 02 03 04 05 06 07
08 09 0a 0b 0c 0d 0e 0f
ret
accept 8
10 11 12 13 14 15 16 17
irq 200
accept 8
40 41 42 43 44 45 46 47
irq 3c0
accept 4
78 79 7a 7b
ret
accept 4
48 49 4a 4b
ret
accept 24
18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27
28 29 2a 2b 2c 2d 2e 2f
irq 100
accept 8
20 21 22 23 24 25 26 27
ret
accept 80
30 31 32 33 34 35 36 37
38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47
48 49 4a 4b 4c 4d 4e 4f
50 51 52 53 54 55 56 57
58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67
68 69 6a 6b 6c 6d 6e 6f
70 71 72 73 74 75 76 77
78 79 7a 7b 7c 7d 7e 7f

// File: design/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// width of an instruction word address
`define ADDR_W 16

// width of an external memory byte address
`define MEM_ADDR_W 28

// width of one instruction word
`define INS_W 64

// words per cache segment
`define ISA_DEPTH 64

// words in the whole program image of two segments
`define TOTAL_ISA_DEPTH 128

// entries in the return address stack
`define STACK_DEPTH 4

`endif

// File: design/fetch_pkg.sv
`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`ADDR_W-1:0]     ins_addr_t;     // instruction word address
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;     // external memory byte address
    typedef logic [`INS_W-1:0]      ins_word_t;
    typedef logic [9:0]             seg_count_t;    // segments held by the cache

    typedef enum logic [2:0]
    {
        START,
        CNT_ADDR,
        LOAD_JMP_ADDR,
        LOAD_RET_ADDR,
        LOAD_RET_END
    } pc_state_t;

    typedef enum logic [1:0]
    {
        FILL_REQ,
        FILL_WAIT,
        FILL_DONE
    } fill_state_t;

endpackage

// File: design/ins_cache.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module ins_cache
(
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::ins_addr_t   addr_ins,
    input  logic                   mem_req_ready,
    input  logic                   mem_rsp_valid,
    input  fetch_pkg::ins_word_t   mem_rsp_data,
    output fetch_pkg::ins_word_t   ins_data,
    output logic                   mem_req_valid,
    output fetch_pkg::mem_addr_t   mem_req_addr,
    output fetch_pkg::seg_count_t  load_times
);

    localparam int IDX_W = $clog2(`TOTAL_ISA_DEPTH);
    localparam int CNT_W = IDX_W + 1;               // counter reaches TOTAL_ISA_DEPTH
    localparam int SEG_W = $clog2(`ISA_DEPTH);

    localparam logic [CNT_W-1:0] FILL_LAST = CNT_W'(`TOTAL_ISA_DEPTH - 1);

    fetch_pkg::ins_word_t    ins_mem [0:`TOTAL_ISA_DEPTH-1];

    fetch_pkg::fill_state_t  fill_state;
    logic [CNT_W-1:0]        fill_cnt;
    logic                    rsp_take;
    logic                    seg_last;
    logic                    seg_done;

    assign rsp_take = (fill_state == fetch_pkg::FILL_WAIT) && mem_rsp_valid;
    assign seg_last = (fill_cnt[SEG_W-1:0] == '1);

    assign mem_req_addr = fetch_pkg::mem_addr_t'(fill_cnt) << 3;   // eight bytes per word
    assign ins_data     = ins_mem[addr_ins[IDX_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (rsp_take)
        begin
            ins_mem[fill_cnt[IDX_W-1:0]] <= mem_rsp_data;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fill_state    <= fetch_pkg::FILL_REQ;
            fill_cnt      <= '0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            case (fill_state)
                fetch_pkg::FILL_REQ:
                begin
                    if (mem_req_valid && mem_req_ready)
                    begin
                        mem_req_valid <= 1'b0;
                        fill_state    <= fetch_pkg::FILL_WAIT;
                    end
                    else
                    begin
                        mem_req_valid <= 1'b1;      // raised one cycle after reset
                    end
                end
                fetch_pkg::FILL_WAIT:
                begin
                    if (mem_rsp_valid)
                    begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_cnt == FILL_LAST)
                        begin
                            fill_state <= fetch_pkg::FILL_DONE;
                        end
                        else
                        begin
                            fill_state    <= fetch_pkg::FILL_REQ;
                            mem_req_valid <= 1'b1;
                        end
                    end
                end
                default:
                begin
                    mem_req_valid <= 1'b0;          // the image is complete so memory stays idle
                end
            endcase
        end
    end

    // segment count moves one cycle after the segment's last write
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            seg_done   <= 1'b0;
            load_times <= '0;
        end
        else
        begin
            seg_done <= rsp_take && seg_last;
            if (seg_done)
            begin
                load_times <= load_times + 1'b1;
            end
        end
    end

endmodule

// File: design/ins_fetch_top.sv
`timescale 1ns/1ps

module ins_fetch_top
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  irq,
    input  fetch_pkg::mem_addr_t  irq_addr,
    input  logic                  ret_valid,
    input  logic                  ins_ready,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  fetch_pkg::ins_word_t  mem_rsp_data,
    output logic                  ins_valid,
    output fetch_pkg::ins_addr_t  ins_addr,
    output fetch_pkg::ins_word_t  ins_data,
    output logic                  mem_req_valid,
    output fetch_pkg::mem_addr_t  mem_req_addr
);

    fetch_pkg::ins_addr_t   addr_ins;
    fetch_pkg::seg_count_t  load_times;
    logic                   push;
    fetch_pkg::ins_addr_t   push_addr;
    logic                   pop;
    fetch_pkg::ins_addr_t   ret_addr;
    logic                   ret_addr_rdy;

    assign ins_addr = addr_ins;

    program_counter u_program_counter
    (
        .clk          (clk),
        .rst          (rst),
        .irq          (irq),
        .irq_addr     (irq_addr),
        .ret_valid    (ret_valid),
        .ins_ready    (ins_ready),
        .ret_addr     (ret_addr),
        .ret_addr_rdy (ret_addr_rdy),
        .load_times   (load_times),
        .addr_ins     (addr_ins),
        .ins_valid    (ins_valid),
        .push         (push),
        .push_addr    (push_addr),
        .pop          (pop)
    );

    ins_cache u_ins_cache
    (
        .clk           (clk),
        .rst           (rst),
        .addr_ins      (addr_ins),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .ins_data      (ins_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .load_times    (load_times)
    );

    ret_addr_stack u_ret_addr_stack
    (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .push_addr    (push_addr),
        .pop          (pop),
        .ret_addr     (ret_addr),
        .ret_addr_rdy (ret_addr_rdy)
    );

endmodule

// File: design/program_counter.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module program_counter
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   irq,
    input  fetch_pkg::mem_addr_t   irq_addr,
    input  logic                   ret_valid,
    input  logic                   ins_ready,
    input  fetch_pkg::ins_addr_t   ret_addr,
    input  logic                   ret_addr_rdy,
    input  fetch_pkg::seg_count_t  load_times,
    output fetch_pkg::ins_addr_t   addr_ins,
    output logic                   ins_valid,
    output logic                   push,
    output fetch_pkg::ins_addr_t   push_addr,
    output logic                   pop
);

    fetch_pkg::pc_state_t  state;
    fetch_pkg::pc_state_t  state_next;

    logic                  irq_pend;        // interrupt seen but not yet taken
    fetch_pkg::mem_addr_t  jmp_byte_addr;
    fetch_pkg::ins_addr_t  jmp_word_addr;
    logic                  ret_valid_q;
    logic                  ret_fall;
    fetch_pkg::ins_addr_t  loaded_words;
    logic                  xfer;

    assign jmp_word_addr = fetch_pkg::ins_addr_t'(jmp_byte_addr >> 3);  // byte to word address
    assign ret_fall      = ret_valid_q & ~ret_valid;
    assign loaded_words  = fetch_pkg::ins_addr_t'(load_times)
                         * fetch_pkg::ins_addr_t'(`ISA_DEPTH);

    // only words the cache has already filled are offered
    assign ins_valid = (state == fetch_pkg::CNT_ADDR)
                     && (addr_ins < fetch_pkg::ins_addr_t'(`TOTAL_ISA_DEPTH))
                     && (addr_ins < loaded_words);
    assign xfer      = ins_valid & ins_ready;

    assign push      = (state == fetch_pkg::LOAD_JMP_ADDR);
    assign push_addr = addr_ins;                            // first word not yet issued
    assign pop       = (state == fetch_pkg::LOAD_RET_END);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            irq_pend    <= 1'b0;
            ret_valid_q <= 1'b0;
        end
        else
        begin
            ret_valid_q <= ret_valid;
            if (irq)
            begin
                irq_pend <= 1'b1;
            end
            else if (state == fetch_pkg::LOAD_JMP_ADDR)
            begin
                irq_pend <= 1'b0;
            end
        end
    end

    // jump target is kept until the jump state consumes it
    always_ff @(posedge clk)
    begin
        if (irq)
        begin
            jmp_byte_addr <= irq_addr;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= fetch_pkg::START;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        case (state)
            fetch_pkg::START:
            begin
                state_next = fetch_pkg::CNT_ADDR;
            end
            fetch_pkg::CNT_ADDR:
            begin
                if (irq || irq_pend)
                begin
                    state_next = fetch_pkg::LOAD_JMP_ADDR;     // interrupt wins over return
                end
                else if (ret_valid)
                begin
                    state_next = fetch_pkg::LOAD_RET_ADDR;
                end
                else
                begin
                    state_next = fetch_pkg::CNT_ADDR;
                end
            end
            fetch_pkg::LOAD_RET_ADDR:
            begin
                if (ret_fall)
                begin
                    state_next = fetch_pkg::LOAD_RET_END;
                end
                else
                begin
                    state_next = fetch_pkg::LOAD_RET_ADDR;
                end
            end
            default:
            begin
                state_next = fetch_pkg::CNT_ADDR;              // jump and return end last one cycle
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            addr_ins <= '0;
        end
        else
        begin
            case (state)
                fetch_pkg::CNT_ADDR:
                begin
                    if (xfer)
                    begin
                        addr_ins <= addr_ins + 1'b1;
                    end
                end
                fetch_pkg::LOAD_JMP_ADDR:
                begin
                    addr_ins <= jmp_word_addr;
                end
                fetch_pkg::LOAD_RET_ADDR:
                begin
                    if (ret_addr_rdy)
                    begin
                        addr_ins <= ret_addr;               // an empty stack keeps the address
                    end
                end
                default:
                begin
                    addr_ins <= addr_ins;
                end
            endcase
        end
    end

endmodule

// File: design/ret_addr_stack.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module ret_addr_stack
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  fetch_pkg::ins_addr_t  push_addr,
    input  logic                  pop,
    output fetch_pkg::ins_addr_t  ret_addr,
    output logic                  ret_addr_rdy
);

    localparam int IDX_W = $clog2(`STACK_DEPTH);

    fetch_pkg::ins_addr_t  stack_mem [0:`STACK_DEPTH-1];

    logic [IDX_W:0]        level;           // number of saved addresses
    logic [IDX_W-1:0]      top_idx;
    logic                  full;
    logic                  push_ok;
    logic                  pop_ok;

    assign full         = (level == (IDX_W+1)'(`STACK_DEPTH));
    assign ret_addr_rdy = (level != '0);
    assign push_ok      = push & ~full;     // pushes onto a full stack are lost
    assign pop_ok       = pop & ret_addr_rdy;
    assign top_idx      = level[IDX_W-1:0] - 1'b1;
    assign ret_addr     = stack_mem[top_idx];

    // push and pop together replace the top entry
    always_ff @(posedge clk)
    begin
        if (push_ok && !pop_ok)
        begin
            stack_mem[level[IDX_W-1:0]] <= push_addr;
        end
        else if (push && pop_ok)
        begin
            stack_mem[top_idx] <= push_addr;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            level <= '0;
        end
        else
        begin
            if (push_ok && !pop_ok)
            begin
                level <= level + 1'b1;
            end
            else if (pop_ok && !push)
            begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

// File: ins_fetch_top.f
+incdir+design
design/fetch_pkg.sv
design/program_counter.sv
design/ins_cache.sv
design/ret_addr_stack.sv
design/ins_fetch_top.sv
bench/ins_fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the fetch testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ins_fetch_tb \
    -f ins_fetch_top.f -o ins_fetch_sim \
    && ./obj_dir/ins_fetch_sim \
    || { echo "simulation build or run failed"; exit 1; }
